//--- logic/ray_config.svh
`ifndef RAY_CONFIG_SVH
`define RAY_CONFIG_SVH

// Scalar format, signed two's complement fixed point
`define RAY_FP_BITS 24

// Fraction bits, so 1.0 is 65536
`define RAY_FRAC_BITS 16

// Push-off along the normal for the new origin, 1/256
`define RAY_EPSILON 24'sh000100

// Cycles from hit_valid to reflect_done
`define RAY_RFLX_DELAY 5

// LFSR start value, must be nonzero
`define RAY_DEFAULT_SEED 48'hA5C3_91E7_2D4B

`endif

//--- logic/ray_pkg.sv
`include "ray_config.svh"

package ray_pkg;

  // One fixed-point scalar
  typedef logic signed [`RAY_FP_BITS-1:0] fp;

  typedef struct packed {
    fp x;
    fp y;
    fp z;
  } fp_vec3;

  // Same layout as fp_vec3
  typedef struct packed {
    fp r;
    fp g;
    fp b;
  } fp_color;

  typedef struct packed {
    fp_color    color;
    fp_color    spec_color;
    fp_color    emit_color;
    fp          smoothness;
    logic [7:0] specular_prob;
  } material;

  // Full product, arithmetic shift by the fraction width, then truncate
  function automatic fp fp_mul(input fp a, input fp b);
    logic signed [2*`RAY_FP_BITS-1:0] full;
    full = a * b;
    return fp'(full >>> `RAY_FRAC_BITS);
  endfunction

  // Component sums wrap at the scalar width
  function automatic fp_vec3 vec_add(input fp_vec3 a, input fp_vec3 b);
    fp_vec3 r;
    r.x = a.x + b.x;
    r.y = a.y + b.y;
    r.z = a.z + b.z;
    return r;
  endfunction

  function automatic fp_vec3 vec_scale(input fp s, input fp_vec3 v);
    fp_vec3 r;
    r.x = fp_mul(s, v.x);
    r.y = fp_mul(s, v.y);
    r.z = fp_mul(s, v.z);
    return r;
  endfunction

  // Componentwise product, used for colour times colour
  function automatic fp_vec3 vec_mul(input fp_vec3 a, input fp_vec3 b);
    fp_vec3 r;
    r.x = fp_mul(a.x, b.x);
    r.y = fp_mul(a.y, b.y);
    r.z = fp_mul(a.z, b.z);
    return r;
  endfunction

endpackage

//--- logic/delay_pipe.sv
`timescale 1ns/100ps
`default_nettype none

// Fixed-depth shift chain, keeps lanes of different latency aligned
module delay_pipe #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1
) (
  input  logic     clk,
  input  logic     rst_n,
  input  payload_t in,
  output payload_t out
);

  payload_t stage [DEPTH];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= in;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign out = stage[DEPTH-1];

endmodule

`default_nettype wire

//--- logic/reflect_rng.sv
`timescale 1ns/100ps
`default_nettype none
`include "ray_config.svh"

// Free-running 48-bit Galois LFSR for the bounce decision and diffuse offset
module reflect_rng (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [47:0]     seed,
  output logic [7:0]      rng_byte,
  output ray_pkg::fp_vec3 rng_vec
);

  import ray_pkg::*;

  // Taps 48, 47, 21, 20 give a maximal-length sequence
  localparam logic [47:0] TAP_MASK = 48'hC000_0018_0000;
  localparam int          EXT_BITS = `RAY_FP_BITS - 16;

  logic [47:0] state;
  logic [47:0] start_value;
  fp           off_x;
  fp           off_y;
  fp           off_z;

  // An all-zero state would lock up
  assign start_value = (seed == '0) ? `RAY_DEFAULT_SEED : seed;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= start_value;
    end else if (state[0]) begin
      state <= {1'b0, state[47:1]} ^ TAP_MASK;
    end else begin
      state <= {1'b0, state[47:1]};
    end
  end

  // Low byte drives the specular decision
  assign rng_byte = state[7:0];

  // 16-bit slices read as pure fractions, range -0.5 to just under 0.5
  // z overlaps the top byte of y's slice, there are only 48 bits
  assign off_x = {{EXT_BITS{state[23]}}, state[23:8]};
  assign off_y = {{EXT_BITS{state[39]}}, state[39:24]};
  assign off_z = {{EXT_BITS{state[47]}}, state[47:32]};

  always_comb begin
    rng_vec.x = off_x;
    rng_vec.y = off_y;
    rng_vec.z = off_z;
  end

endmodule

`default_nettype wire

//--- logic/specular_reflect.sv
`timescale 1ns/100ps
`default_nettype none

// Mirror reflection: in_dir - 2 * dot(in_dir, normal) * normal, 3 cycles
module specular_reflect (
  input  logic            clk,
  input  logic            rst_n,
  input  ray_pkg::fp_vec3 in_dir,
  input  ray_pkg::fp_vec3 normal,
  output ray_pkg::fp_vec3 out_dir
);

  import ray_pkg::*;

  fp      dot_raw;
  fp      two_dot;

  // Stage 1 results and the operands that travel with them
  fp      dot_s1;
  fp_vec3 dir_s1;
  fp_vec3 normal_s1;

  // Stage 2 results
  fp_vec3 scaled_s2;
  fp_vec3 dir_s2;

  // Each product truncated before the wrapping sum
  assign dot_raw = fp_mul(in_dir.x, normal.x)
                 + fp_mul(in_dir.y, normal.y)
                 + fp_mul(in_dir.z, normal.z);

  // Doubling before the multiply
  assign two_dot = dot_s1 + dot_s1;

  // Dot product
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dot_s1    <= '0;
      dir_s1    <= '0;
      normal_s1 <= '0;
    end else begin
      dot_s1    <= dot_raw;
      dir_s1    <= in_dir;
      normal_s1 <= normal;
    end
  end

  // Twice the dot times the normal
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      scaled_s2 <= '0;
      dir_s2    <= '0;
    end else begin
      scaled_s2 <= vec_scale(two_dot, normal_s1);
      dir_s2    <= dir_s1;
    end
  end

  // Subtract from the incoming direction
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_dir <= '0;
    end else begin
      out_dir.x <= dir_s2.x - scaled_s2.x;
      out_dir.y <= dir_s2.y - scaled_s2.y;
      out_dir.z <= dir_s2.z - scaled_s2.z;
    end
  end

endmodule

`default_nettype wire

//--- logic/vec3_lerp.sv
`timescale 1ns/100ps
`default_nettype none

// lerped = t * w + (1 - t) * v, two cycles
module vec3_lerp (
  input  logic            clk,
  input  logic            rst_n,
  input  ray_pkg::fp_vec3 v,
  input  ray_pkg::fp_vec3 w,
  input  ray_pkg::fp      t,
  input  ray_pkg::fp      one_sub_t,
  output ray_pkg::fp_vec3 lerped
);

  import ray_pkg::*;

  // Scaled operands after stage 1
  fp_vec3 w_scaled;
  fp_vec3 v_scaled;

  // One_sub_t comes precomputed from the caller
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w_scaled <= '0;
      v_scaled <= '0;
    end else begin
      w_scaled <= vec_scale(t, w);
      v_scaled <= vec_scale(one_sub_t, v);
    end
  end

  // Sum of the two weighted terms
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lerped <= '0;
    end else begin
      lerped <= vec_add(w_scaled, v_scaled);
    end
  end

endmodule

`default_nettype wire

//--- logic/ray_reflector.sv
`timescale 1ns/100ps
`default_nettype none
`include "ray_config.svh"

// Bounce stage: new direction, origin, colour and light for one hit per cycle
module ray_reflector (
  input  logic             clk,
  input  logic             rst_n,

  input  ray_pkg::fp_vec3  ray_dir,
  input  ray_pkg::fp_color ray_color,
  input  ray_pkg::fp_color income_light,

  input  ray_pkg::fp_vec3  hit_pos,
  input  ray_pkg::fp_vec3  hit_normal,
  input  ray_pkg::material hit_mat,
  input  logic             hit_valid,

  input  logic [47:0]      lfsr_seed,

  output ray_pkg::fp_vec3  new_dir,
  output ray_pkg::fp_vec3  new_origin,
  output ray_pkg::fp_color new_color,
  output ray_pkg::fp_color new_income_light,
  output logic             reflect_done
);

  import ray_pkg::*;

  localparam fp  FP_ONE       = fp'(1 << `RAY_FRAC_BITS);
  localparam fp  EPSILON      = fp'(`RAY_EPSILON);
  // Lanes registered at cycle 1 that feed the direction lerp at cycle 3
  localparam int DIR_ALIGN    = 2;
  // Lanes registered at cycle 1 that run straight to the output
  localparam int OUT_ALIGN    = `RAY_RFLX_DELAY - 1;
  // Colour product lands at cycle 4
  localparam int COLOR_ALIGN  = `RAY_RFLX_DELAY - 4;

  delay_pipe #(.payload_t(logic), .DEPTH(`RAY_RFLX_DELAY)) u_done_pipe (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (hit_valid),
    .out   (reflect_done)
  );

  // Specular decision
  logic [7:0] rng_byte;
  fp_vec3     rng_vec;
  fp          spec_amt;
  fp          spec_amt_q;
  fp          one_sub_q;

  reflect_rng u_rng (
    .clk      (clk),
    .rst_n    (rst_n),
    .seed     (lfsr_seed),
    .rng_byte (rng_byte),
    .rng_vec  (rng_vec)
  );

  // Strictly below, so a probability of 0 never bounces specular
  assign spec_amt = (rng_byte < hit_mat.specular_prob) ? hit_mat.smoothness : '0;

  // Cycle 1 registers
  fp_vec3  diffuse_q;
  fp_vec3  origin_q;
  fp_color light_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      spec_amt_q <= '0;
      one_sub_q  <= '0;
      diffuse_q  <= '0;
      origin_q   <= '0;
      light_q    <= '0;
    end else begin
      spec_amt_q <= spec_amt;
      one_sub_q  <= FP_ONE - spec_amt;
      // Unnormalised, lands in the normal's hemisphere
      diffuse_q  <= vec_add(rng_vec, hit_normal);
      origin_q   <= vec_add(hit_pos, vec_scale(EPSILON, hit_normal));
      light_q    <= vec_add(income_light, vec_mul(ray_color, hit_mat.emit_color));
    end
  end

  // Direction branch
  fp_vec3 specular_dir;
  fp_vec3 diffuse_d3;
  fp      spec_amt_d3;
  fp      one_sub_d3;

  specular_reflect u_spec_reflect (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_dir  (ray_dir),
    .normal  (hit_normal),
    .out_dir (specular_dir)
  );

  delay_pipe #(.payload_t(fp_vec3), .DEPTH(DIR_ALIGN)) u_diffuse_pipe (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (diffuse_q),
    .out   (diffuse_d3)
  );

  delay_pipe #(.payload_t(fp), .DEPTH(DIR_ALIGN)) u_spec_amt_pipe (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (spec_amt_q),
    .out   (spec_amt_d3)
  );

  delay_pipe #(.payload_t(fp), .DEPTH(DIR_ALIGN)) u_one_sub_pipe (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (one_sub_q),
    .out   (one_sub_d3)
  );

  // Full specular weight picks the mirror direction
  vec3_lerp u_dir_lerp (
    .clk       (clk),
    .rst_n     (rst_n),
    .v         (diffuse_d3),
    .w         (specular_dir),
    .t         (spec_amt_d3),
    .one_sub_t (one_sub_d3),
    .lerped    (new_dir)
  );

  // Origin and light run straight to the output
  delay_pipe #(.payload_t(fp_vec3), .DEPTH(OUT_ALIGN)) u_origin_pipe (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (origin_q),
    .out   (new_origin)
  );

  delay_pipe #(.payload_t(fp_color), .DEPTH(OUT_ALIGN)) u_light_pipe (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (light_q),
    .out   (new_income_light)
  );

  // Colour branch
  fp_color mat_color_d1;
  fp_color mat_spec_d1;
  fp_color ray_color_d3;
  fp_vec3  true_mat_color;
  fp_color color_prod_q;

  delay_pipe #(.payload_t(fp_color), .DEPTH(1)) u_mat_color_pipe (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (hit_mat.color),
    .out   (mat_color_d1)
  );

  delay_pipe #(.payload_t(fp_color), .DEPTH(1)) u_mat_spec_pipe (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (hit_mat.spec_color),
    .out   (mat_spec_d1)
  );

  // Same weight as the direction, two cycles earlier
  vec3_lerp u_color_lerp (
    .clk       (clk),
    .rst_n     (rst_n),
    .v         (mat_color_d1),
    .w         (mat_spec_d1),
    .t         (spec_amt_q),
    .one_sub_t (one_sub_q),
    .lerped    (true_mat_color)
  );

  delay_pipe #(.payload_t(fp_color), .DEPTH(3)) u_ray_color_pipe (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (ray_color),
    .out   (ray_color_d3)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      color_prod_q <= '0;
    end else begin
      color_prod_q <= vec_mul(ray_color_d3, true_mat_color);
    end
  end

  delay_pipe #(.payload_t(fp_color), .DEPTH(COLOR_ALIGN)) u_new_color_pipe (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (color_prod_q),
    .out   (new_color)
  );

endmodule

`default_nettype wire

//--- verification/ray_reflector_assertions.sv
`timescale 1ns/100ps
`include "ray_config.svh"

// Handshake and unknown-value checks, bound into ray_reflector
module ray_reflector_assertions (
  input logic             clk,
  input logic             rst_n,
  input logic             hit_valid,
  input logic             reflect_done,
  input ray_pkg::fp_vec3  new_dir,
  input ray_pkg::fp_vec3  new_origin,
  input ray_pkg::fp_color new_color,
  input ray_pkg::fp_color new_income_light
);

  // Number of failed assertions, read by the testbench at the end
  int unsigned failures = 0;

  // One done pulse per hit, at the fixed pipeline distance
  property done_follows_hit;
    @(posedge clk) disable iff (!rst_n)
      reflect_done == $past(hit_valid, `RAY_RFLX_DELAY);
  endproperty

  property done_low_in_reset;
    @(posedge clk) !rst_n |-> !reflect_done;
  endproperty

  // All result fields resolved when the result is marked
  property outputs_known;
    @(posedge clk) disable iff (!rst_n)
      reflect_done |-> !$isunknown({new_dir, new_origin, new_color, new_income_light});
  endproperty

  a_done_follows_hit: assert property (done_follows_hit) else begin
    $error("reflect_done does not match hit_valid from the pipeline depth earlier");
    failures++;
  end

  a_done_low_in_reset: assert property (done_low_in_reset) else begin
    $error("reflect_done is high while reset is active");
    failures++;
  end

  a_outputs_known: assert property (outputs_known) else begin
    $error("Result outputs hold unknown bits while reflect_done is high");
    failures++;
  end

endmodule

//--- verification/tb_ray_reflector.sv
`timescale 1ns/100ps
`include "ray_config.svh"

module tb_ray_reflector;

  import ray_pkg::*;

  localparam int  CLK_PERIOD   = 40;
  localparam int  RESET_CYCLES = 3;
  localparam int  N_HITS       = 200;
  localparam int  SEED         = 47;
  localparam time WATCHDOG_NS  = (N_HITS + 20) * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;
  localparam fp   ONE          = fp'(1 << `RAY_FRAC_BITS);
  localparam fp   EPS          = fp'(`RAY_EPSILON);
  localparam int  HALF         = 1 << (`RAY_FRAC_BITS - 1);
  localparam int  DIR_SKIP     = 0;
  localparam int  DIR_EXACT    = 1;
  localparam int  DIR_HEMI     = 2;

  typedef struct {
    fp_vec3  dir;
    fp_vec3  normal;
    fp_vec3  origin;
    fp_color light;
    fp_color color;
    fp_color alt_color;
    int      dir_mode;
  } expect_t;

  logic        clk;
  logic        rst_n;
  fp_vec3      ray_dir;
  fp_color     ray_color;
  fp_color     income_light;
  fp_vec3      hit_pos;
  fp_vec3      hit_normal;
  material     hit_mat;
  logic        hit_valid;
  logic [47:0] lfsr_seed;
  fp_vec3      new_dir;
  fp_vec3      new_origin;
  fp_color     new_color;
  fp_color     new_income_light;
  logic        reflect_done;

  expect_t exp_q[$];
  int      hit_count = 0;
  int      done_count = 0;
  int      mismatches = 0;
  int      other_errors = 0;

  ray_reflector u_dut (.*);

  bind ray_reflector ray_reflector_assertions u_assertions (
    .clk              (clk),
    .rst_n            (rst_n),
    .hit_valid        (hit_valid),
    .reflect_done     (reflect_done),
    .new_dir          (new_dir),
    .new_origin       (new_origin),
    .new_color        (new_color),
    .new_income_light (new_income_light)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Reference arithmetic: full product, shift by the fraction width, truncate
  function automatic fp fix_mul(input fp a, input fp b);
    longint prod;
    prod = longint'(a) * longint'(b);
    return fp'(prod >>> `RAY_FRAC_BITS);
  endfunction

  function automatic fp_vec3 add3(input fp_vec3 a, input fp_vec3 b);
    fp_vec3 r;
    r.x = a.x + b.x;
    r.y = a.y + b.y;
    r.z = a.z + b.z;
    return r;
  endfunction

  function automatic fp_vec3 scale3(input fp s, input fp_vec3 v);
    fp_vec3 r;
    r.x = fix_mul(s, v.x);
    r.y = fix_mul(s, v.y);
    r.z = fix_mul(s, v.z);
    return r;
  endfunction

  function automatic fp_vec3 mul3(input fp_vec3 a, input fp_vec3 b);
    fp_vec3 r;
    r.x = fix_mul(a.x, b.x);
    r.y = fix_mul(a.y, b.y);
    r.z = fix_mul(a.z, b.z);
    return r;
  endfunction

  // t * w + (1 - t) * v
  function automatic fp_vec3 blend3(input fp_vec3 v, input fp_vec3 w, input fp t);
    return add3(scale3(t, w), scale3(ONE - t, v));
  endfunction

  function automatic fp_vec3 mirror_dir(input fp_vec3 d, input fp_vec3 n);
    fp      dot;
    fp      twice;
    fp_vec3 r;
    dot = fix_mul(d.x, n.x) + fix_mul(d.y, n.y) + fix_mul(d.z, n.z);
    twice = dot + dot;
    r.x = d.x - fix_mul(twice, n.x);
    r.y = d.y - fix_mul(twice, n.y);
    r.z = d.z - fix_mul(twice, n.z);
    return r;
  endfunction

  // Uniform in -2.0 .. +2.0
  function automatic fp rand_fix();
    int v;
    v = int'($urandom_range(262144)) - 131072;
    return fp'(v);
  endfunction

  function automatic fp_vec3 rand_vec();
    fp_vec3 r;
    r.x = rand_fix();
    r.y = rand_fix();
    r.z = rand_fix();
    return r;
  endfunction

  function automatic fp rand_smooth();
    return fp'($urandom_range(65536));
  endfunction

  // Unit axis vector with random sign
  function automatic fp_vec3 unit_normal();
    fp_vec3 n;
    fp      val;
    int     axis;
    axis = int'($urandom_range(2));
    val = ($urandom_range(1) == 1) ? -ONE : ONE;
    n = '0;
    case (axis)
      0: n.x = val;
      1: n.y = val;
      default: n.z = val;
    endcase
    return n;
  endfunction

  task automatic compare_word(input string name, input logic [71:0] exp_v,
                              input logic [71:0] got_v);
    assert (got_v === exp_v) else begin
      $display("MISMATCH %s expected %h got %h", name, exp_v, got_v);
      mismatches++;
    end
  endtask

  task automatic hemisphere_axis(input string axis, input fp nc, input fp gc);
    int diff;
    diff = int'(gc) - int'(nc);
    assert (diff >= -HALF && diff <= HALF) else begin
      $display("Diffuse direction %s component %h is more than one half from normal %h",
               axis, gc, nc);
      other_errors++;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      hit_valid = 1'b0;
    end
  endtask

  // Drives one hit and queues its expected result
  task automatic send_hit(input logic [7:0] prob, input fp smooth, input bit exact_color);
    material mat;
    fp_vec3  d;
    fp_vec3  n;
    fp_vec3  p;
    fp_color rc;
    fp_color il;
    fp_color spec_pred;
    fp_color diff_pred;
    expect_t e;
    bit      spec;
    d = rand_vec();
    n = unit_normal();
    p = rand_vec();
    rc = rand_vec();
    il = rand_vec();
    mat.color = rand_vec();
    mat.spec_color = rand_vec();
    mat.emit_color = rand_vec();
    mat.smoothness = smooth;
    mat.specular_prob = prob;
    @(negedge clk);
    ray_dir = d;
    ray_color = rc;
    income_light = il;
    hit_pos = p;
    hit_normal = n;
    hit_mat = mat;
    hit_valid = 1'b1;
    // Decision byte of the free-running LFSR in this cycle
    spec = (u_dut.rng_byte < prob);
    spec_pred = mul3(rc, blend3(mat.color, mat.spec_color, smooth));
    diff_pred = mul3(rc, blend3(mat.color, mat.spec_color, '0));
    e.normal = n;
    e.origin = add3(p, scale3(EPS, n));
    e.light = add3(il, mul3(rc, mat.emit_color));
    e.dir = mirror_dir(d, n);
    if (exact_color) begin
      e.color = spec ? spec_pred : diff_pred;
      e.alt_color = e.color;
    end else begin
      e.color = spec_pred;
      e.alt_color = diff_pred;
    end
    if (!spec) e.dir_mode = DIR_HEMI;
    else if (smooth == ONE) e.dir_mode = DIR_EXACT;
    else e.dir_mode = DIR_SKIP;
    exp_q.push_back(e);
    hit_count++;
  endtask

  // Scoreboard, outputs are stable at the falling edge
  always @(negedge clk) begin
    expect_t e;
    if (rst_n && reflect_done) begin
      done_count++;
      if (exp_q.size() == 0) begin
        $display("Done pulse at %0t with no hit outstanding", $time);
        other_errors++;
      end else begin
        e = exp_q.pop_front();
        compare_word("new_origin", e.origin, new_origin);
        compare_word("new_income_light", e.light, new_income_light);
        assert ((new_color === e.color) || (new_color === e.alt_color)) else begin
          $display("MISMATCH new_color expected %h or %h got %h",
                   e.color, e.alt_color, new_color);
          mismatches++;
        end
        if (e.dir_mode == DIR_EXACT) begin
          compare_word("new_dir", e.dir, new_dir);
        end else if (e.dir_mode == DIR_HEMI) begin
          hemisphere_axis("x", e.normal.x, new_dir.x);
          hemisphere_axis("y", e.normal.y, new_dir.y);
          hemisphere_axis("z", e.normal.z, new_dir.z);
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the test sequence finished");
    $display("Verification failed");
    $finish;
  end

  initial begin
    int waited;
    void'($urandom(SEED));
    rst_n = 1'b0;
    hit_valid = 1'b0;
    ray_dir = '0;
    ray_color = '0;
    income_light = '0;
    hit_pos = '0;
    hit_normal = '0;
    hit_mat = '0;
    lfsr_seed = `RAY_DEFAULT_SEED;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    // No hits yet, so no done pulse may appear
    idle_cycles(3);
    // Specular with full smoothness, back to back
    repeat (64) send_hit(8'd255, ONE, 1'b1);
    idle_cycles(2);
    // Never specular
    repeat (64) send_hit(8'd0, rand_smooth(), 1'b1);
    idle_cycles(2);
    // Mixed probabilities
    repeat (72) send_hit(8'($urandom_range(255)), rand_smooth(), 1'b0);
    idle_cycles(1);
    waited = 0;
    while (exp_q.size() > 0 && waited < 2 * `RAY_RFLX_DELAY) begin
      @(negedge clk);
      waited++;
    end
    idle_cycles(2);
    if (exp_q.size() != 0) begin
      $display("%0d hits never produced a result", exp_q.size());
      other_errors++;
    end
    if (done_count != hit_count) begin
      $display("Sent %0d hits but saw %0d done pulses", hit_count, done_count);
      other_errors++;
    end
    if (u_dut.u_assertions.failures != 0) begin
      $display("%0d bound assertion failures", u_dut.u_assertions.failures);
      other_errors++;
    end
    $display("Hits %0d, results %0d, mismatches %0d, other errors %0d",
             hit_count, done_count, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+logic
logic/ray_pkg.sv
logic/delay_pipe.sv
logic/reflect_rng.sv
logic/specular_reflect.sv
logic/vec3_lerp.sv
logic/ray_reflector.sv
verification/ray_reflector_assertions.sv
verification/tb_ray_reflector.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ray reflector testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
EXE=sim_ray_reflector

verilator --binary --timing --assert -f files.f --top-module tb_ray_reflector -o "$EXE"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Verification passed" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
